/* verilog.f */
+incdir+.
uart_pkg.sv
uart_baud_timer.sv
uart_fifo.sv
uart_ser.sv
uart_des.sv
uart_regs.sv
uart_top.sv
tb_uart_top.sv

/* tb_uart_top.sv */
////////////////////////////////////////////////////////////
// testbench for the UART controller on the bus and both serial pins
// runs a frame table in a loop with LFSR bytes and a serial line model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module tb_uart_top;

  import uart_pkg::*;

  localparam int n_rows = 6;

  // one table entry
  typedef struct packed {
    bdr_t bdr;
    cnt_t n;
    logic inj;
  } row_t;

  logic  clk      = 1'b0;
  logic  rst_n    = 1'b0;
  logic  bus_vld  = 1'b0;
  logic  bus_wen  = 1'b0;
  adr_t  bus_adr  = '0;
  word_t bus_wdt  = '0;
  word_t bus_rdt;
  logic  uart_rxd = 1'b1;
  logic  uart_txd;

  row_t            frame_tbl [n_rows];
  logic [31:0]     lfsr = 32'hd96b_c94d;
  // clocks per bit on both line models
  int unsigned     cur_p = `UART_BDR_RST + 1;
  longint unsigned wd_ns = 0;

  // expected bytes and frames waiting for the rxd driver
  data_t      tx_exp [$];
  data_t      rx_exp [$];
  logic [8:0] rx_q [$];
  logic       rx_busy = 1'b0;

  always #2 clk = ~clk;

  uart_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus_vld  (bus_vld),
    .bus_wen  (bus_wen),
    .bus_adr  (bus_adr),
    .bus_wdt  (bus_wdt),
    .bus_rdt  (bus_rdt),
    .uart_rxd (uart_rxd),
    .uart_txd (uart_txd)
  );

  ////////////////////////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_data(input string sig, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cnt(input string sig, input cnt_t exp, input cnt_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%0d actual=%0d", $time, sig, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string sig, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, sig, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, sig, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // random bytes and the frame table
  ////////////////////////////////////////////////////////////

  // right shifting Galois form
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one step per bit
  function automatic data_t rand_byte();
    data_t b;
    for (int i = 0; i < `UART_DW; i++) begin
      lfsr = lfsr_next(lfsr);
      b[i] = lfsr[0];
    end
    return b;
  endfunction

  function automatic row_t make_row(input bdr_t bdr, input cnt_t n, input logic inj);
    row_t r;
    r.bdr = bdr;
    r.n   = n;
    r.inj = inj;
    return r;
  endfunction

  task automatic load_table();
    frame_tbl[0] = make_row(16'd15, 5'd4, 1'b0);
    frame_tbl[1] = make_row(16'd3, 5'd16, 1'b0);
    frame_tbl[2] = make_row(16'd40, 5'd5, 1'b1);
    frame_tbl[3] = make_row(16'd3, 5'd8, 1'b1);
    frame_tbl[4] = make_row(16'd15, 5'd12, 1'b1);
    frame_tbl[5] = make_row(16'd3, 5'd10, 1'b0);
  endtask

  // every frame at the slowest bit period and doubled
  function automatic longint unsigned watchdog_limit();
    longint unsigned frames;
    longint unsigned max_p;
    frames = 17;
    max_p  = `UART_BDR_RST + 1;
    for (int r = 0; r < n_rows; r++) begin
      frames += 2 * frame_tbl[r].n + frame_tbl[r].inj;
      if (frame_tbl[r].bdr + 1 > max_p) begin
        max_p = frame_tbl[r].bdr + 1;
      end
    end
    return 2 * frames * 10 * max_p * 4;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus access
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input adr_t adr, input word_t wdt);
    @(posedge clk);
    bus_vld <= 1'b1;
    bus_wen <= 1'b1;
    bus_adr <= adr;
    bus_wdt <= wdt;
    @(posedge clk);
    bus_vld <= 1'b0;
    bus_wen <= 1'b0;
  endtask

  // read data lands one cycle after the request
  task automatic bus_read(input adr_t adr, output word_t rdt);
    @(posedge clk);
    bus_vld <= 1'b1;
    bus_wen <= 1'b0;
    bus_adr <= adr;
    @(posedge clk);
    bus_vld <= 1'b0;
    @(negedge clk);
    rdt = bus_rdt;
  endtask

  task automatic poll_tx_room();
    word_t w;
    cnt_t  c;
    c = 5'd16;
    while (c >= 5'd16) begin
      bus_read(`UART_REG_STAT, w);
      // a STAT read clears the sticky flags
      check_bit("stat overrun", 1'b0, w[17]);
      check_bit("stat framing error", 1'b0, w[16]);
      c = w[4:0];
    end
  endtask

  task automatic poll_rx_count(input cnt_t n);
    word_t w;
    cnt_t  c;
    c = '0;
    while (c != n) begin
      bus_read(`UART_REG_STAT, w);
      check_bit("stat overrun", 1'b0, w[17]);
      check_bit("stat framing error", 1'b0, w[16]);
      c = w[12:8];
    end
  endtask

  task automatic read_rx_bytes(input int n);
    word_t w;
    data_t exp;
    for (int i = 0; i < n; i++) begin
      bus_read(`UART_REG_DATA, w);
      exp = rx_exp.pop_front();
      check_bit("data rx valid", 1'b1, w[8]);
      check_data("data rx byte", exp, w[7:0]);
    end
  endtask

  task automatic wait_rx_idle();
    wait ((rx_q.size() == 0) && (rx_busy == 1'b0));
  endtask

  ////////////////////////////////////////////////////////////
  // serial line model
  ////////////////////////////////////////////////////////////

  // txd sampled mid-bit on the falling clock
  initial begin : txd_monitor
    int unsigned p;
    data_t       got;
    data_t       exp;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (uart_txd === 1'b0) begin
        p = cur_p;
        if (tx_exp.size() == 0) begin
          $display("start bit seen on txd with no byte written to the TX FIFO");
          abort_run();
        end
        repeat (p / 2) @(negedge clk);
        check_bit("txd start bit", 1'b0, uart_txd);
        for (int i = 0; i < `UART_DW; i++) begin
          repeat (p) @(negedge clk);
          got[i] = uart_txd;
        end
        repeat (p) @(negedge clk);
        check_bit("txd stop bit", 1'b1, uart_txd);
        exp = tx_exp.pop_front();
        check_data("txd byte", exp, got);
      end
    end
  end

  // bit 8 of a queued frame is the stop bit level
  initial begin : rxd_driver
    logic [8:0]  frm;
    int unsigned p;
    forever begin
      wait (rx_q.size() != 0);
      rx_busy = 1'b1;
      while (rx_q.size() != 0) begin
        frm = rx_q.pop_front();
        p = cur_p;
        @(posedge clk);
        uart_rxd <= 1'b0;
        for (int i = 0; i < `UART_DW; i++) begin
          repeat (p) @(posedge clk);
          uart_rxd <= frm[i];
        end
        repeat (p) @(posedge clk);
        uart_rxd <= frm[8];
        repeat (p) @(posedge clk);
        uart_rxd <= 1'b1;
      end
      // one idle bit so the receiver has finished
      repeat (p) @(posedge clk);
      rx_busy = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////////////////////////

  task automatic run_row(input row_t row);
    word_t w;
    data_t b;
    bus_write(`UART_REG_BDR, {16'd0, row.bdr});
    bus_read(`UART_REG_BDR, w);
    check_word("bdr", {16'd0, row.bdr}, w);
    // both line models idle here
    cur_p = row.bdr + 1;
    if (row.inj) begin
      // low stop bit
      rx_q.push_back({1'b0, rand_byte()});
      wait_rx_idle();
      bus_read(`UART_REG_STAT, w);
      check_bit("stat framing error", 1'b1, w[16]);
      check_bit("stat overrun", 1'b0, w[17]);
      check_cnt("stat rx count", 5'd0, w[12:8]);
      bus_read(`UART_REG_STAT, w);
      check_bit("stat framing error after clear", 1'b0, w[16]);
    end
    // receive runs while the transmit side is loaded
    for (int i = 0; i < row.n; i++) begin
      b = rand_byte();
      rx_exp.push_back(b);
      rx_q.push_back({1'b1, b});
    end
    for (int i = 0; i < row.n; i++) begin
      b = rand_byte();
      poll_tx_room();
      tx_exp.push_back(b);
      bus_write(`UART_REG_DATA, {24'd0, b});
    end
    poll_rx_count(row.n);
    read_rx_bytes(row.n);
    wait (tx_exp.size() == 0);
    wait_rx_idle();
    bus_read(`UART_REG_STAT, w);
    check_cnt("stat tx count", 5'd0, w[4:0]);
    check_cnt("stat rx count", 5'd0, w[12:8]);
    check_bit("stat overrun", 1'b0, w[17]);
    check_bit("stat framing error", 1'b0, w[16]);
  endtask

  // one frame more than the RX FIFO holds
  task automatic run_overrun();
    word_t w;
    data_t b;
    for (int i = 0; i < 17; i++) begin
      b = rand_byte();
      rx_q.push_back({1'b1, b});
      if (i < 16) begin
        rx_exp.push_back(b);
      end
    end
    wait_rx_idle();
    bus_read(`UART_REG_STAT, w);
    check_cnt("stat rx count", 5'd16, w[12:8]);
    check_bit("stat overrun", 1'b1, w[17]);
    check_bit("stat framing error", 1'b0, w[16]);
    read_rx_bytes(16);
    bus_read(`UART_REG_STAT, w);
    check_bit("stat overrun after clear", 1'b0, w[17]);
    check_cnt("stat rx count", 5'd0, w[12:8]);
  endtask

  initial begin : reset_gen
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

  initial begin : watchdog
    wait (wd_ns != 0);
    #(wd_ns);
    $display("timeout after %0d ns, the DUT never finished the frame table", wd_ns);
    abort_run();
  end

  initial begin : main_seq
    word_t w;
    load_table();
    wd_ns = watchdog_limit();
    wait (rst_n === 1'b1);
    @(negedge clk);

    // reset state
    check_bit("uart_txd", 1'b1, uart_txd);
    bus_read(`UART_REG_STAT, w);
    check_word("stat", 32'd0, w);
    // empty RX FIFO reads as zero
    bus_read(`UART_REG_DATA, w);
    check_word("data", 32'd0, w);
    bus_read(`UART_REG_BDR, w);
    check_word("bdr", {16'd0, `UART_BDR_RST}, w);
    check_bit("uart_txd", 1'b1, uart_txd);

    for (int r = 0; r < n_rows; r++) begin
      run_row(frame_tbl[r]);
    end
    run_overrun();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* uart_top.sv */
////////////////////////////////////////////////////////////
// UART controller top, register bus in and serial pins out
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_top (
  input  logic            clk,
  input  logic            rst_n,
  // register bus
  input  logic            bus_vld,
  input  logic            bus_wen,
  input  uart_pkg::adr_t  bus_adr,
  input  uart_pkg::word_t bus_wdt,
  output uart_pkg::word_t bus_rdt,
  // serial pins
  input  logic            uart_rxd,
  output logic            uart_txd
);

  import uart_pkg::*;

  // registers to FIFOs
  logic  txf_vld, rxf_vld;
  data_t txf_dat, rxf_dat;
  logic  txf_rdy, rxf_rdy;
  cnt_t  txf_cnt, rxf_cnt;

  // FIFOs to serdes
  logic  txs_vld, rxs_vld;
  data_t txs_dat, rxs_dat;
  logic  txs_rdy, rxs_rdy;

  logic  frm_err;
  bdr_t  cfg_bdr;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  uart_regs regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt),
    .txf_vld (txf_vld),
    .txf_dat (txf_dat),
    .txf_rdy (txf_rdy),
    .txf_cnt (txf_cnt),
    .rxf_vld (rxf_vld),
    .rxf_dat (rxf_dat),
    .rxf_rdy (rxf_rdy),
    .rxf_cnt (rxf_cnt),
    .rxs_vld (rxs_vld),
    .rxs_rdy (rxs_rdy),
    .frm_err (frm_err),
    .cfg_bdr (cfg_bdr)
  );

  ////////////////////////////////////////////////////////////
  // TX channel
  ////////////////////////////////////////////////////////////

  uart_fifo tx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .sti_vld (txf_vld),
    .sti_dat (txf_dat),
    .sti_rdy (txf_rdy),
    .sto_vld (txs_vld),
    .sto_dat (txs_dat),
    .sto_rdy (txs_rdy),
    .cnt     (txf_cnt)
  );

  uart_ser ser (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_bdr (cfg_bdr),
    .str_vld (txs_vld),
    .str_dat (txs_dat),
    .str_rdy (txs_rdy),
    .txd     (uart_txd)
  );

  ////////////////////////////////////////////////////////////
  // RX channel
  ////////////////////////////////////////////////////////////

  uart_fifo rx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .sti_vld (rxs_vld),
    .sti_dat (rxs_dat),
    .sti_rdy (rxs_rdy),
    .sto_vld (rxf_vld),
    .sto_dat (rxf_dat),
    .sto_rdy (rxf_rdy),
    .cnt     (rxf_cnt)
  );

  uart_des des (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_bdr (cfg_bdr),
    .rxd     (uart_rxd),
    .str_vld (rxs_vld),
    .str_dat (rxs_dat),
    .frm_err (frm_err)
  );

endmodule

/* uart_regs.sv */
////////////////////////////////////////////////////////////
// bus register file, FIFO access, baud and status flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_regs (
  input  logic            clk,
  input  logic            rst_n,
  // register bus
  input  logic            bus_vld,
  input  logic            bus_wen,
  input  uart_pkg::adr_t  bus_adr,
  input  uart_pkg::word_t bus_wdt,
  output uart_pkg::word_t bus_rdt,
  // TX FIFO write side
  output logic            txf_vld,
  output uart_pkg::data_t txf_dat,
  input  logic            txf_rdy,
  input  uart_pkg::cnt_t  txf_cnt,
  // RX FIFO read side
  input  logic            rxf_vld,
  input  uart_pkg::data_t rxf_dat,
  output logic            rxf_rdy,
  input  uart_pkg::cnt_t  rxf_cnt,
  // receiver status
  input  logic            rxs_vld,
  input  logic            rxs_rdy,
  input  logic            frm_err,
  // bit period to both serdes
  output uart_pkg::bdr_t  cfg_bdr
);

  import uart_pkg::*;

  logic  wr_req;
  logic  rd_req;
  logic  stat_rd;
  // sticky flags
  logic  ovr;
  logic  ferr;
  word_t rd_mux;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  assign wr_req  = bus_vld && bus_wen;
  assign rd_req  = bus_vld && !bus_wen;
  assign stat_rd = rd_req && (bus_adr == `UART_REG_STAT);

  // push dropped when the TX FIFO is full
  assign txf_vld = wr_req && (bus_adr == `UART_REG_DATA) && txf_rdy;
  assign txf_dat = bus_wdt[`UART_DW-1:0];
  // pop only takes effect when rxf_vld
  assign rxf_rdy = rd_req && (bus_adr == `UART_REG_DATA);

  always_comb begin
    case (bus_adr)
      `UART_REG_DATA: rd_mux = rxf_vld ? {23'd0, 1'b1, rxf_dat} : '0;
      `UART_REG_STAT: rd_mux = {14'd0, ovr, ferr, 3'd0, rxf_cnt, 3'd0, txf_cnt};
      `UART_REG_BDR:  rd_mux = {{(32-`UART_CW){1'b0}}, cfg_bdr};
      default:        rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_bdr <= `UART_BDR_RST;
      bus_rdt <= '0;
      ovr     <= 1'b0;
      ferr    <= 1'b0;
    end else begin
      if (wr_req && (bus_adr == `UART_REG_BDR)) begin
        cfg_bdr <= bus_wdt[`UART_CW-1:0];
      end
      // read data holds between reads
      if (rd_req) begin
        bus_rdt <= rd_mux;
      end
      // a new event wins over the clearing read
      ovr  <= (ovr && !stat_rd) || (rxs_vld && !rxs_rdy);
      ferr <= (ferr && !stat_rd) || frm_err;
    end
  end

endmodule

/* uart_des.sv */
////////////////////////////////////////////////////////////
// UART receiver, 8N1 frames sampled mid-bit
// good bytes pulse str_vld, bad stop bits pulse frm_err
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_des (
  input  logic            clk,
  input  logic            rst_n,
  // configuration
  input  uart_pkg::bdr_t  cfg_bdr,
  // serial input
  input  logic            rxd,
  // parallel stream, no ready
  output logic            str_vld,
  output uart_pkg::data_t str_dat,
  // stop bit was low
  output logic            frm_err
);

  import uart_pkg::*;

  // two-flop synchronizer
  logic [1:0] sync;
  logic       rxd_s;

  des_state_t state;
  logic [2:0] idx;
  // line still low after a bad stop bit
  logic       hold;
  data_t      sh;
  logic       tim_run;
  logic       half;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // line idles high
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rxd};
    end
  end

  assign rxd_s = sync[1];

  ////////////////////////////////////////////////////////////
  // bit timing
  ////////////////////////////////////////////////////////////

  // timer starts in the same cycle the edge shows up
  assign tim_run = (state != des_idle) || !rxd_s;

  uart_baud_timer tmr (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (tim_run),
    .cfg_bdr (cfg_bdr),
    .half    (half),
    .tick    ()
  );

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= des_idle;
      idx     <= '0;
      hold    <= 1'b0;
      str_vld <= 1'b0;
      frm_err <= 1'b0;
    end else begin
      // single cycle pulses
      str_vld <= 1'b0;
      frm_err <= 1'b0;
      case (state)
        des_idle: begin
          if (!rxd_s) begin
            state <= des_start;
          end
        end
        des_start: begin
          if (half) begin
            // glitch returns to idle
            state <= rxd_s ? des_idle : des_data;
            idx   <= '0;
          end
        end
        des_data: begin
          if (half) begin
            if (idx == 3'd7) begin
              state <= des_stop;
            end
            idx <= idx + 3'd1;
          end
        end
        des_stop: begin
          if (hold) begin
            // wait out a break
            if (rxd_s) begin
              state <= des_idle;
              hold  <= 1'b0;
            end
          end else if (half) begin
            if (rxd_s) begin
              str_vld <= 1'b1;
              state   <= des_idle;
            end else begin
              frm_err <= 1'b1;
              hold    <= 1'b1;
            end
          end
        end
        default: state <= des_idle;
      endcase
    end
  end

  // LSB arrives first and ends up at bit 0
  always_ff @(posedge clk) begin
    if (half && (state == des_data)) begin
      sh <= {rxd_s, sh[`UART_DW-1:1]};
    end
  end

  assign str_dat = sh;

endmodule

/* uart_ser.sv */
////////////////////////////////////////////////////////////
// UART transmitter, 8N1 frames from a valid/ready stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_ser (
  input  logic            clk,
  input  logic            rst_n,
  // configuration
  input  uart_pkg::bdr_t  cfg_bdr,
  // parallel stream
  input  logic            str_vld,
  input  uart_pkg::data_t str_dat,
  output logic            str_rdy,
  // serial output
  output logic            txd
);

  import uart_pkg::*;

  ser_state_t state;
  // data bit index
  logic [2:0] idx;
  // byte shifts out LSB first
  data_t      sh;
  // period of the frame in flight
  bdr_t       bdr_q;
  bdr_t       tim_bdr;
  logic       tim_run;
  logic       tick;

  ////////////////////////////////////////////////////////////
  // bit timing
  ////////////////////////////////////////////////////////////

  assign tim_run = (state != ser_idle);

  // accept when idle or at the end of the stop bit
  assign str_rdy = str_vld && ((state == ser_idle) || ((state == ser_stop) && tick));

  // new frame takes the live period
  assign tim_bdr = str_rdy ? cfg_bdr : bdr_q;

  uart_baud_timer tmr (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (tim_run),
    .cfg_bdr (tim_bdr),
    .half    (),
    .tick    (tick)
  );

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ser_idle;
      idx   <= '0;
      txd   <= 1'b1;
    end else begin
      case (state)
        ser_idle: begin
          if (str_rdy) begin
            state <= ser_start;
            txd   <= 1'b0;
          end
        end
        ser_start: begin
          if (tick) begin
            state <= ser_data;
            idx   <= '0;
            txd   <= sh[0];
          end
        end
        ser_data: begin
          if (tick) begin
            if (idx == 3'd7) begin
              state <= ser_stop;
              txd   <= 1'b1;
            end else begin
              idx <= idx + 3'd1;
              txd <= sh[0];
            end
          end
        end
        ser_stop: begin
          // back to back frames skip idle
          if (str_rdy) begin
            state <= ser_start;
            txd   <= 1'b0;
          end else if (tick) begin
            state <= ser_idle;
          end
        end
        default: state <= ser_idle;
      endcase
    end
  end

  // shift register and frame period
  always_ff @(posedge clk) begin
    if (str_rdy) begin
      sh    <= str_dat;
      bdr_q <= cfg_bdr;
    end else if (tick && (state != ser_stop)) begin
      sh <= sh >> 1;
    end
  end

endmodule

/* uart_fifo.sv */
////////////////////////////////////////////////////////////
// synchronous byte FIFO with valid/ready on both sides
// shared depth for the TX and RX channels
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_fifo (
  input  logic            clk,
  input  logic            rst_n,
  // write side
  input  logic            sti_vld,
  input  uart_pkg::data_t sti_dat,
  output logic            sti_rdy,
  // read side
  output logic            sto_vld,
  output uart_pkg::data_t sto_dat,
  input  logic            sto_rdy,
  // occupancy
  output uart_pkg::cnt_t  cnt
);

  import uart_pkg::*;

  localparam int unsigned fifo_aw = `UART_FIFO_AW;
  localparam int unsigned fifo_sz = 2**fifo_aw;

  // storage
  data_t mem [fifo_sz];

  // pointers carry one extra wrap bit
  logic [fifo_aw:0] wr_ptr;
  logic [fifo_aw:0] rd_ptr;

  logic full;
  logic empty;
  logic push;
  logic pop;

  ////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////

  // same address, same wrap bit
  assign empty = (wr_ptr == rd_ptr);
  // same address, opposite wrap bit
  assign full  = (wr_ptr == {~rd_ptr[fifo_aw], rd_ptr[fifo_aw-1:0]});

  assign cnt = wr_ptr - rd_ptr;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  assign sto_vld = !empty;
  // a pop in the same cycle frees a slot when full
  assign sti_rdy = !full || sto_rdy;

  assign push = sti_vld && sti_rdy;
  assign pop  = sto_vld && sto_rdy;

  // head of queue
  assign sto_dat = mem[rd_ptr[fifo_aw-1:0]];

  ////////////////////////////////////////////////////////////
  // pointers and storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[fifo_aw-1:0]] <= sti_dat;
    end
  end

endmodule

/* uart_baud_timer.sv */
////////////////////////////////////////////////////////////
// bit period timer for one serdes block
// runs while start is high, preloads the period while low
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_baud_timer (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  uart_pkg::bdr_t cfg_bdr,
  output logic           half,
  output logic           tick
);

  import uart_pkg::*;

  // down counter
  bdr_t cnt;
  // mid-period count value
  bdr_t mid;

  assign mid = cfg_bdr >> 1;

  ////////////////////////////////////////////////////////////
  // counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!start) begin
      // idle, hold the full period ready
      cnt <= cfg_bdr;
    end else if (cnt == '0) begin
      // wrap and restart the next period
      cnt <= cfg_bdr;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // tick outputs
  ////////////////////////////////////////////////////////////

  // end of each bit period
  assign tick = start && (cnt == '0);

  // middle of each bit period
  // first one lands mid start bit when start follows the edge
  assign half = start && (cnt == mid);

endmodule

/* uart_pkg.sv */
////////////////////////////////////////////////////////////
// UART types shared by the RTL and the testbench
////////////////////////////////////////////////////////////

`include "uart_macros.svh"

package uart_pkg;

  // one UART byte
  typedef logic [`UART_DW-1:0] data_t;

  // bit period minus one, in clock cycles
  typedef logic [`UART_CW-1:0] bdr_t;

  // FIFO occupancy, 0 to full depth
  typedef logic [`UART_FIFO_AW:0] cnt_t;

  // register index and bus word
  typedef logic [1:0]  adr_t;
  typedef logic [31:0] word_t;

  // serializer FSM
  typedef enum logic [1:0] {
    ser_idle,
    ser_start,
    ser_data,
    ser_stop
  } ser_state_t;

  // deserializer FSM
  typedef enum logic [1:0] {
    des_idle,
    des_start,
    des_data,
    des_stop
  } des_state_t;

endpackage

/* uart_macros.svh */
////////////////////////////////////////////////////////////
// UART widths, FIFO depth and register map
// include wherever a macro is needed
////////////////////////////////////////////////////////////

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// byte and baud counter widths
`define UART_DW 8
`define UART_CW 16

// FIFO address width, depth is 2**AW
`define UART_FIFO_AW 4

// bit period minus one after reset, 16 clocks per bit
`define UART_BDR_RST 16'd15

// register indices
`define UART_REG_DATA 2'd0
`define UART_REG_STAT 2'd1
`define UART_REG_BDR  2'd2

`endif
